// File: eth_latency_measurer.f
verilog/eth_frame_pkg.sv
verilog/latency_pkg.sv
verilog/checksum_calculator.sv
verilog/eth_latency_measurer_tx.sv
verilog/eth_latency_measurer_rx.sv
verilog/ping_sequencer.sv
verilog/eth_latency_measurer.sv
dv/echo_responder.sv
dv/eth_latency_measurer_tb.sv

// File: dv/eth_latency_measurer_tb.sv
/*
	Testbench for the ping latency measurer
	Checks frame bytes, framing, latency, reply filtering and timeouts
*/

`timescale 1ns/1ns

module eth_latency_measurer_tb;
	import latency_pkg::*;

	localparam int NUM_PINGS = 7;

	logic clk;
	logic rst;
	meas_cfg_t cfg;
	logic start;
	logic [7:0] m_axis_tdata;
	logic m_axis_tkeep;
	logic m_axis_tlast;
	logic m_axis_tvalid;
	logic m_axis_tready;
	logic [7:0] s_axis_tdata;
	logic s_axis_tvalid;
	logic s_axis_tlast;
	logic busy;
	logic result_valid;
	latency_result_t result;

	logic stall_en;
	logic drop_reply;
	logic bad_log_id;
	logic stale_id;

	logic [7:0] exp_frame [0:255];
	int exp_len;
	logic [15:0] exp_id;
	logic exp_timeout;
	logic [31:0] exp_latency;
	logic [31:0] cycle = '0;
	logic [31:0] first_tx_edge = '0;
	logic [31:0] last_rx_edge = '0;
	int tx_idx = 0;
	int frames_sent = 0;
	int frames_started = 0;
	int pings_issued = 0;
	int value_errors = 0;
	int other_errors = 0;

	assign exp_latency = exp_timeout ? 32'(TIMEOUT_CYCLES) : last_rx_edge - first_tx_edge + 32'd1;

	eth_latency_measurer #(.C_MODE(0)) eth_latency_measurer_i (
		.clk(clk),
		.rst(rst),
		.cfg(cfg),
		.start(start),
		.m_axis_tdata(m_axis_tdata),
		.m_axis_tkeep(m_axis_tkeep),
		.m_axis_tlast(m_axis_tlast),
		.m_axis_tvalid(m_axis_tvalid),
		.m_axis_tready(m_axis_tready),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tvalid(s_axis_tvalid),
		.s_axis_tlast(s_axis_tlast),
		.busy(busy),
		.result_valid(result_valid),
		.result(result)
	);

	echo_responder responder_i (
		.clk(clk),
		.rst(rst),
		.tx_data(m_axis_tdata),
		.tx_valid(m_axis_tvalid),
		.tx_ready(m_axis_tready),
		.tx_last(m_axis_tlast),
		.drop(drop_reply),
		.bad_log_id(bad_log_id),
		.stale_id(stale_id),
		.rx_data(s_axis_tdata),
		.rx_valid(s_axis_tvalid),
		.rx_last(s_axis_tlast)
	);

	task automatic report_mismatch(input string msg);
		value_errors++;
		$display("FAILED %0t: %s", $time, msg);
	endtask

	// Internet checksum over exp_frame[first .. last-1]
	function automatic logic [15:0] inet_checksum(input int first, input int last);
		logic [31:0] acc;
		acc = '0;
		for (int i = first; i < last; i += 2)
			acc = acc + {16'h0000, exp_frame[i], exp_frame[i + 1]};
		while (acc[31:16] != 16'h0000)
			acc = {16'h0000, acc[15:0]} + {16'h0000, acc[31:16]};
		return ~acc[15:0];
	endfunction

	task automatic build_frame(input logic [15:0] id);
		logic [335:0] hdr;
		logic [15:0] csum;
		hdr = {cfg.mac_dst, cfg.mac_src, 16'h0800, 16'h4500, 16'h001C, id, 16'h4000,
			8'h40, 8'h01, 16'h0000, cfg.ip_src, cfg.ip_dst,
			8'h08, 8'h00, 16'h0000, cfg.log_id, cfg.ping_id};
		exp_len = 64 + int'(cfg.padding_size);
		for (int i = 0; i < 42; i++)
			exp_frame[i] = hdr[335 - 8*i -: 8];
		for (int i = 42; i < exp_len; i++)
			exp_frame[i] = 8'h55;
		csum = inet_checksum(14, 34); // IPv4 header
		exp_frame[24] = csum[15:8];
		exp_frame[25] = csum[7:0];
		csum = inet_checksum(34, 42);
		exp_frame[36] = csum[15:8];
		exp_frame[37] = csum[7:0];
	endtask

	task automatic run_ping(input logic [15:0] pad, input logic drop, input logic bad_log,
		input logic stale, input logic stall);
		int unsigned waited;
		@(posedge clk);
		#10;
		cfg.padding_size = pad;
		drop_reply = drop;
		bad_log_id = bad_log;
		stale_id = stale;
		stall_en = stall;
		build_frame(16'(pings_issued));
		exp_id = 16'(pings_issued);
		exp_timeout = drop || bad_log || stale;
		start = 1'b1;
		@(posedge clk);
		#10;
		start = 1'b0;
		waited = 0;
		while (frames_sent != pings_issued + 1 && waited < 1000) begin
			@(posedge clk);
			#10;
			waited++;
		end
		if (frames_sent != pings_issued + 1) begin
			other_errors++;
			$display("Frame for ping %0d not sent within %0d cycles", pings_issued, waited);
		end
		// Builder idle again while the reply is still pending
		assert (busy) else report_mismatch("busy low during ping");
		start = 1'b1; // Must be ignored
		@(posedge clk);
		#10;
		start = 1'b0;
		waited = 0;
		while (!result_valid && waited < TIMEOUT_CYCLES + 200) begin
			@(posedge clk);
			#10;
			waited++;
		end
		if (!result_valid) begin
			other_errors++;
			$display("No result for ping %0d within %0d cycles", pings_issued, waited);
		end else begin
			assert (!busy) else report_mismatch("busy high with result_valid");
			assert (frames_started == pings_issued + 1)
			else report_mismatch($sformatf("%0d frames started, expected %0d",
				frames_started, pings_issued + 1));
		end
		pings_issued++;
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		#10;
		m_axis_tready = !stall_en || ($urandom_range(0, 3) != 0);
	end

	// Tx byte checker and edge bookkeeping
	always @(posedge clk) begin
		cycle <= cycle + 32'd1;
		if (!rst && m_axis_tvalid && m_axis_tready) begin
			if (tx_idx == 0) begin
				first_tx_edge = cycle;
				frames_started++;
			end
			assert (m_axis_tdata == exp_frame[tx_idx] && m_axis_tkeep == 1'b1 &&
				m_axis_tlast == (tx_idx == exp_len - 1))
			else report_mismatch($sformatf("tx byte %0d: %h keep %b last %b, expected %h of %0d",
				tx_idx, m_axis_tdata, m_axis_tkeep, m_axis_tlast, exp_frame[tx_idx], exp_len));
			if (m_axis_tlast) begin
				tx_idx = 0;
				frames_sent++;
			end else begin
				tx_idx++;
			end
		end
		if (!rst && s_axis_tvalid && s_axis_tlast)
			last_rx_edge = cycle;
	end

	assert property (@(posedge clk) disable iff (rst)
		m_axis_tvalid && !m_axis_tready |=>
			m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
	else report_mismatch("tx byte changed while stalled");

	assert property (@(posedge clk) disable iff (rst) result_valid |->
		result.frame_id == exp_id && result.timed_out == exp_timeout &&
		result.latency == exp_latency)
	else report_mismatch($sformatf("result id %0d timeout %b latency %0d, expected %0d %b %0d",
		result.frame_id, result.timed_out, result.latency, exp_id, exp_timeout, exp_latency));

	assert property (@(posedge clk) disable iff (rst) result_valid |=> !result_valid)
	else report_mismatch("result_valid longer than one cycle");

	initial begin
		repeat ((NUM_PINGS + 1) * (TIMEOUT_CYCLES + 200)) @(posedge clk);
		$display("Watchdog expired before all pings finished");
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'h9ad8));
		rst = 1'b1;
		start = 1'b0;
		m_axis_tready = 1'b0;
		stall_en = 1'b0;
		drop_reply = 1'b0;
		bad_log_id = 1'b0;
		stale_id = 1'b0;
		exp_len = 64;
		exp_id = '0;
		exp_timeout = 1'b0;
		cfg.mac_src = 48'h02_00_00_00_00_01;
		cfg.ip_src = 32'hC0A8_0001;
		cfg.mac_dst = 48'h02_00_00_00_00_02;
		cfg.ip_dst = 32'hC0A8_0002;
		cfg.padding_size = '0;
		cfg.log_id = 16'($urandom);
		cfg.ping_id = 16'($urandom);
		repeat (4) @(posedge clk);
		#10;
		rst = 1'b0;
		@(posedge clk);
		#10;
		assert (!m_axis_tvalid && !busy && !result_valid)
		else report_mismatch("outputs not idle after reset");

		run_ping(16'd0, 1'b0, 1'b0, 1'b0, 1'b0);
		run_ping(16'($urandom_range(1, 40)), 1'b0, 1'b0, 1'b0, 1'b1);
		run_ping(16'($urandom_range(1, 40)), 1'b0, 1'b0, 1'b0, 1'b1);
		run_ping(16'd0, 1'b1, 1'b0, 1'b0, 1'b0); // Lost reply
		run_ping(16'($urandom_range(1, 40)), 1'b0, 1'b1, 1'b0, 1'b1);
		run_ping(16'($urandom_range(1, 40)), 1'b0, 1'b0, 1'b1, 1'b0);
		run_ping(16'($urandom_range(1, 40)), 1'b0, 1'b0, 1'b0, 1'b1);

		repeat (20) @(posedge clk);
		#10;
		assert (frames_sent == NUM_PINGS)
		else report_mismatch($sformatf("%0d frames sent for %0d pings", frames_sent, NUM_PINGS));

		$display("Pings %0d, value errors %0d, other errors %0d",
			pings_issued, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: dv/echo_responder.sv
/*
	Testbench link partner
	Captures each transmitted frame and plays it back as an echo reply
*/

`timescale 1ns/1ns

module echo_responder (
	input logic clk,
	input logic rst,
	input logic [7:0] tx_data,
	input logic tx_valid,
	input logic tx_ready,
	input logic tx_last,
	input logic drop,
	input logic bad_log_id,
	input logic stale_id,
	output logic [7:0] rx_data,
	output logic rx_valid,
	output logic rx_last
);
	logic [7:0] frame [$];
	logic done;

	task automatic play_reply();
		logic [7:0] b [$];
		logic [15:0] id;
		int gap;
		b = frame;
		for (int i = 0; i < 6; i++) begin // Swap MACs
			b[i] = frame[6 + i];
			b[6 + i] = frame[i];
		end
		for (int i = 0; i < 4; i++) begin // Swap IPs
			b[26 + i] = frame[30 + i];
			b[30 + i] = frame[26 + i];
		end
		b[34] = 8'h00;
		if (bad_log_id)
			b[39] = b[39] ^ 8'h01;
		if (stale_id) begin
			id = {frame[18], frame[19]} - 16'd1; // Id of the previous ping
			b[18] = id[15:8];
			b[19] = id[7:0];
		end
		gap = $urandom_range(2, 40);
		repeat (gap) @(posedge clk);
		for (int i = 0; i < b.size(); i++) begin
			@(posedge clk);
			#10;
			rx_data = b[i];
			rx_valid = 1'b1;
			rx_last = (i == b.size() - 1);
		end
		@(posedge clk);
		#10;
		rx_valid = 1'b0;
		rx_last = 1'b0;
	endtask

	initial begin
		rx_data = 8'h00;
		rx_valid = 1'b0;
		rx_last = 1'b0;
		forever begin
			frame.delete();
			done = 1'b0;
			while (!done) begin
				@(posedge clk);
				if (!rst && tx_valid && tx_ready) begin
					frame.push_back(tx_data);
					done = tx_last;
				end
			end
			if (!drop)
				play_reply();
		end
	end

endmodule

// File: verilog/eth_latency_measurer.sv
/*
	Ethernet ping latency measurer
	Reply parser, ping sequencer and echo frame builder
*/

`timescale 1ns/1ns

module eth_latency_measurer #(
	parameter int C_MODE = 0
) (
	input logic clk,
	input logic rst,
	input latency_pkg::meas_cfg_t cfg,
	input logic start,
	output logic [7:0] m_axis_tdata,
	output logic m_axis_tkeep,
	output logic m_axis_tlast,
	output logic m_axis_tvalid,
	input logic m_axis_tready,
	input logic [7:0] s_axis_tdata,
	input logic s_axis_tvalid,
	input logic s_axis_tlast,
	output logic busy,
	output logic result_valid,
	output latency_pkg::latency_result_t result
);
	import eth_frame_pkg::*;

	logic trigger;
	logic tx_begin;
	logic [15:0] frame_id;
	logic reply_valid;
	reply_info_t reply;

	eth_latency_measurer_rx rx_i (
		.clk(clk),
		.rst(rst),
		.cfg(cfg),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tvalid(s_axis_tvalid),
		.s_axis_tlast(s_axis_tlast),
		.reply_valid(reply_valid),
		.reply(reply)
	);

	ping_sequencer seq_i (
		.clk(clk),
		.rst(rst),
		.start(start),
		.tx_begin(tx_begin),
		.reply_valid(reply_valid),
		.reply(reply),
		.trigger(trigger),
		.frame_id(frame_id),
		.busy(busy),
		.result_valid(result_valid),
		.result(result)
	);

	eth_latency_measurer_tx #(.C_MODE(C_MODE)) tx_i (
		.clk(clk),
		.rst(rst),
		.trigger(trigger),
		.tx_begin(tx_begin),
		.cfg(cfg),
		.frame_id(frame_id),
		.m_axis_tdata(m_axis_tdata),
		.m_axis_tkeep(m_axis_tkeep),
		.m_axis_tlast(m_axis_tlast),
		.m_axis_tvalid(m_axis_tvalid),
		.m_axis_tready(m_axis_tready)
	);

endmodule

// File: verilog/ping_sequencer.sv
/*
	Ping sequencer
	Issues one echo per start, numbers frames and times the round trip
*/

`timescale 1ns/1ns

module ping_sequencer (
	input logic clk,
	input logic rst,
	input logic start,
	input logic tx_begin,
	input logic reply_valid,
	input eth_frame_pkg::reply_info_t reply,
	output logic trigger,
	output logic [15:0] frame_id,
	output logic busy,
	output logic result_valid,
	output latency_pkg::latency_result_t result
);
	import latency_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_WAIT_TX, ST_TIMING} state_t;

	state_t state;
	logic [31:0] elapsed;
	logic matched;
	logic expired;

	assign matched = reply_valid && (reply.frame_id == frame_id); // Stale replies ignored
	assign expired = (elapsed + 32'd1 == 32'(TIMEOUT_CYCLES));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			trigger <= 1'b0;
			busy <= 1'b0;
			result_valid <= 1'b0;
			frame_id <= '0;
		end else begin
			trigger <= 1'b0;
			result_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start) begin
						state <= ST_WAIT_TX;
						trigger <= 1'b1;
						busy <= 1'b1;
					end
				end
				ST_WAIT_TX: begin
					if (tx_begin)
						state <= ST_TIMING;
				end
				ST_TIMING: begin
					if (matched || expired) begin
						state <= ST_IDLE;
						busy <= 1'b0;
						result_valid <= 1'b1;
						frame_id <= frame_id + 16'd1; // Next ping gets a fresh id
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_WAIT_TX)
			elapsed <= '0;
		else if (state == ST_TIMING)
			elapsed <= elapsed + 32'd1;

		if (state == ST_TIMING && (matched || expired)) begin
			result.frame_id <= frame_id;
			result.timed_out <= !matched;
			result.latency <= matched ? elapsed + 32'd1 : 32'(TIMEOUT_CYCLES);
		end
	end

	// Builder only starts a frame that was asked for
	assert property (@(posedge clk) disable iff (rst) tx_begin |-> state == ST_WAIT_TX);

endmodule

// File: verilog/eth_latency_measurer_rx.sv
/*
	Echo reply parser
	Checks each header byte of the incoming stream against this station
	and reports the identifiers of a matching ICMP echo reply
*/

`timescale 1ns/1ns

module eth_latency_measurer_rx (
	input logic clk,
	input logic rst,
	input latency_pkg::meas_cfg_t cfg,
	input logic [7:0] s_axis_tdata,
	input logic s_axis_tvalid,
	input logic s_axis_tlast,
	output logic reply_valid,
	output eth_frame_pkg::reply_info_t reply
);
	import eth_frame_pkg::*;

	logic [15:0] count;
	logic hdr_ok; // All checked bytes so far matched
	logic checked;
	logic [7:0] exp_byte;
	logic byte_ok;
	logic frame_ok;
	reply_info_t info, info_next;

	// Expected value of the byte at the current position
	always_comb begin
		checked = 1'b1;
		exp_byte = 8'h00;
		case (count) inside
			[16'd0:16'd5]: exp_byte = cfg.mac_src[8*(5-count) +: 8];
			16'd12: exp_byte = ETHERTYPE_IPV4[15:8];
			16'd13: exp_byte = ETHERTYPE_IPV4[7:0];
			16'd23: exp_byte = IP_PROTO_ICMP;
			[16'd26:16'd29]: exp_byte = cfg.ip_dst[8*(29-count) +: 8]; // Reply comes from peer
			[16'd30:16'd33]: exp_byte = cfg.ip_src[8*(33-count) +: 8];
			16'd34: exp_byte = ICMP_ECHO_REPLY;
			[16'd38:16'd39]: exp_byte = cfg.log_id[8*(39-count) +: 8];
			[16'd40:16'd41]: exp_byte = cfg.ping_id[8*(41-count) +: 8];
			default: checked = 1'b0;
		endcase
	end

	assign byte_ok = !checked || (s_axis_tdata == exp_byte);
	assign frame_ok = hdr_ok && byte_ok && (count >= 16'(HDR_BYTES - 1));

	always_comb begin
		info_next = info;
		case (count)
			16'd18: info_next.frame_id[15:8] = s_axis_tdata;
			16'd19: info_next.frame_id[7:0] = s_axis_tdata;
			16'd38: info_next.log_id[15:8] = s_axis_tdata;
			16'd39: info_next.log_id[7:0] = s_axis_tdata;
			16'd40: info_next.ping_id[15:8] = s_axis_tdata;
			16'd41: info_next.ping_id[7:0] = s_axis_tdata;
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
			hdr_ok <= 1'b0;
			reply_valid <= 1'b0;
		end else begin
			reply_valid <= s_axis_tvalid && s_axis_tlast && frame_ok;
			if (s_axis_tvalid) begin
				hdr_ok <= ((count == 16'd0) || hdr_ok) && byte_ok;
				if (s_axis_tlast)
					count <= '0;
				else if (count != 16'hFFFF)
					count <= count + 16'd1; // Saturates on long frames
			end
		end
	end

	always_ff @(posedge clk) begin
		if (s_axis_tvalid)
			info <= info_next;
		if (s_axis_tvalid && s_axis_tlast)
			reply <= info_next;
	end

	// Frames are far longer than one byte
	assert property (@(posedge clk) disable iff (rst) reply_valid |=> !reply_valid);

endmodule

// File: verilog/eth_latency_measurer_tx.sv
/*
	ICMP echo frame builder
	Serializes Ethernet, IPv4 and ICMP headers with checksums, then pads
*/

`timescale 1ns/1ns

module eth_latency_measurer_tx #(
	parameter int C_MODE = 0
) (
	input logic clk,
	input logic rst,
	input logic trigger,
	output logic tx_begin,
	input latency_pkg::meas_cfg_t cfg,
	input logic [15:0] frame_id,
	output logic [7:0] m_axis_tdata,
	output logic m_axis_tkeep,
	output logic m_axis_tlast,
	output logic m_axis_tvalid,
	input logic m_axis_tready
);
	import eth_frame_pkg::*;

	typedef enum logic [1:0] {ST_WAIT_TRIGGER, ST_SEND_HEADERS, ST_SEND_PADDING} state_t;

	state_t state, state_next;
	logic [15:0] count, count_next;
	logic [335:0] tx_buffer, tx_buffer_next;
	logic [15:0] ip_checksum, icmp_checksum;
	logic [7:0] icmp_type;
	logic load;
	logic hdr_last;
	logic pad_last;

	assign icmp_type = (C_MODE != 0) ? ICMP_ECHO_REPLY : ICMP_ECHO_REQUEST;
	assign load = trigger && (state == ST_WAIT_TRIGGER);
	assign hdr_last = (count == 16'(HDR_BYTES - 1));
	assign pad_last = (count == cfg.padding_size + 16'(PAD_BASE - 1));

	assign m_axis_tkeep = 1'b1;
	assign m_axis_tvalid = (state != ST_WAIT_TRIGGER);
	assign m_axis_tlast = (state == ST_SEND_PADDING) && pad_last;
	assign tx_begin = (state == ST_SEND_HEADERS) && (count == 16'd0) && m_axis_tready;

	always_comb begin
		case (state)
			ST_SEND_HEADERS: m_axis_tdata = tx_buffer[335:328];
			ST_SEND_PADDING: m_axis_tdata = 8'h55;
			default: m_axis_tdata = 8'h00;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_WAIT_TRIGGER;
			count <= '0;
		end else begin
			state <= state_next;
			count <= count_next;
		end
	end

	always_ff @(posedge clk)
		tx_buffer <= tx_buffer_next;

	always_comb begin
		state_next = state;
		count_next = count;
		tx_buffer_next = tx_buffer;

		case (state)
			ST_WAIT_TRIGGER: begin
				if (trigger) begin
					state_next = ST_SEND_HEADERS;
					count_next = '0;
					// Fixed IPv4 words match IP_CONST_SUM, checksum fields zero for now
					tx_buffer_next = {cfg.mac_dst, cfg.mac_src, ETHERTYPE_IPV4,
						16'h4500, 16'h001C, frame_id, 16'h4000, 8'h40, IP_PROTO_ICMP,
						16'h0000, cfg.ip_src, cfg.ip_dst,
						icmp_type, 8'h00, 16'h0000, cfg.log_id, cfg.ping_id};
				end
			end

			ST_SEND_HEADERS: begin
				if (m_axis_tready) begin
					count_next = hdr_last ? 16'd0 : count + 16'd1;
					if (hdr_last)
						state_next = ST_SEND_PADDING;

					case (count)
						16'd23: tx_buffer_next = {ip_checksum, tx_buffer[311:0], 8'd0}; // Bytes 24-25
						16'd35: tx_buffer_next = {icmp_checksum, tx_buffer[311:0], 8'd0}; // Bytes 36-37
						default: tx_buffer_next = {tx_buffer[327:0], 8'd0};
					endcase
				end
			end

			ST_SEND_PADDING: begin
				if (m_axis_tready) begin
					if (pad_last) begin
						count_next = '0;
						state_next = ST_WAIT_TRIGGER;
					end else begin
						count_next = count + 16'd1;
					end
				end
			end

			default: state_next = ST_WAIT_TRIGGER;
		endcase
	end

	checksum_calculator #(.N(6)) ip_csum_i (
		.clk(clk),
		.rst(rst),
		.trigger(load),
		.values({frame_id, cfg.ip_dst, cfg.ip_src, IP_CONST_SUM}),
		.checksum(ip_checksum)
	);

	if (C_MODE != 0) begin : g_reply
		// Type and code both zero, nothing to add
		checksum_calculator #(.N(2)) icmp_csum_i (
			.clk(clk),
			.rst(rst),
			.trigger(load),
			.values({cfg.ping_id, cfg.log_id}),
			.checksum(icmp_checksum)
		);
	end else begin : g_request
		checksum_calculator #(.N(3)) icmp_csum_i (
			.clk(clk),
			.rst(rst),
			.trigger(load),
			.values({cfg.ping_id, cfg.log_id, icmp_type, 8'h00}),
			.checksum(icmp_checksum)
		);
	end

	assert property (@(posedge clk) disable iff (rst)
		m_axis_tvalid && !m_axis_tready |=>
			m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast));

	assert property (@(posedge clk) disable iff (rst) m_axis_tlast |-> m_axis_tvalid);

endmodule

// File: verilog/checksum_calculator.sv
/*
	One's-complement checksum over N 16-bit words
	Adds one word per cycle with end-around carry, then inverts
*/

`timescale 1ns/1ns

module checksum_calculator #(
	parameter int N = 2
) (
	input logic clk,
	input logic rst,
	input logic trigger,
	input logic [N*16-1:0] values,
	output logic [15:0] checksum
);
	logic [N*16-1:0] words;
	logic [15:0] sum;
	logic [16:0] sum_raw;
	logic [7:0] remaining;
	logic busy;

	assign sum_raw = {1'b0, sum} + {1'b0, words[15:0]};

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			remaining <= '0;
			sum <= '0;
			checksum <= '0;
		end else if (trigger) begin
			busy <= 1'b1;
			remaining <= 8'(N);
			sum <= '0;
		end else if (busy) begin
			if (remaining != 8'd0) begin
				sum <= sum_raw[15:0] + 16'(sum_raw[16]); // End-around carry
				remaining <= remaining - 8'd1;
			end else begin
				checksum <= ~sum;
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (trigger)
			words <= values;
		else if (busy)
			words <= words >> 16; // Next word to the bottom
	end

	// Builder must not reload before the previous sum is out
	assert property (@(posedge clk) disable iff (rst) busy |-> !trigger);

endmodule

// File: verilog/latency_pkg.sv
/*
	Latency measurement definitions
	Station configuration, per-ping result and the loss timeout
*/

package latency_pkg;

	// Held stable for the duration of a ping
	typedef struct packed {
		logic [47:0] mac_src;
		logic [31:0] ip_src;
		logic [47:0] mac_dst;
		logic [31:0] ip_dst;
		logic [15:0] padding_size;
		logic [15:0] log_id;
		logic [15:0] ping_id;
	} meas_cfg_t;

	typedef struct packed {
		logic [15:0] frame_id;
		logic timed_out;
		logic [31:0] latency; // Clock cycles, first tx byte to reply
	} latency_result_t;

	// A ping with no reply after this many cycles counts as lost
	localparam int unsigned TIMEOUT_CYCLES = 2000;

endpackage

// File: verilog/eth_frame_pkg.sv
/*
	Ethernet, IPv4 and ICMP echo frame definitions
	Field constants, header and pad lengths, parsed reply record
*/

package eth_frame_pkg;

	// Ethernet 14 + IPv4 20 + ICMP 8
	localparam int HDR_BYTES = 42;

	// Pad bytes on top of padding_size, gives a 64 byte minimum frame
	localparam int PAD_BASE = 22;

	localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
	localparam logic [7:0] IP_PROTO_ICMP = 8'd1;

	localparam logic [7:0] ICMP_ECHO_REQUEST = 8'd8;
	localparam logic [7:0] ICMP_ECHO_REPLY = 8'd0;

	// 4500 + 001C + 4000 + 4001, the IPv4 words that never change
	localparam logic [15:0] IP_CONST_SUM = 16'hC51D;

	// Identifiers pulled out of a matching echo reply
	typedef struct packed {
		logic [15:0] frame_id; // IP identification
		logic [15:0] log_id; // ICMP identifier
		logic [15:0] ping_id; // ICMP sequence number
	} reply_info_t;

endpackage
